/* bench/flow_control_assertions.sv */
// Bound into flow_control; reads the internal registered jump of the arbiter
`timescale 1ns/1ps

module flow_control_assertions
    import flow_pkg::*;
#(
    parameter pc_t PC_INIT = '0
)
(
    input logic clock,
    input logic rst_n,
    input logic ior,
    input logic jump,
    input logic cancel,
    input pc_t  pc
);

    // ------------------------------------------------------------
    // Arbiter and PC rules
    // ------------------------------------------------------------

    a_cancel_needs_jump: assert property (@(posedge clock) disable iff (!rst_n)
        cancel |-> jump) else $error("cancel without registered jump");

    a_reset_pc: assert property (@(posedge clock) !rst_n |-> pc == PC_INIT)
        else $error("pc not at reset value during reset");

    a_sequential: assert property (@(posedge clock) disable iff (!rst_n)
        ior && !jump |=> pc == pc_t'($past(pc) + 1)) else $error("pc did not increment");

    a_stall_hold: assert property (@(posedge clock) disable iff (!rst_n)
        !ior |=> pc == $past(pc)) else $error("pc moved during stall");

endmodule

bind flow_control flow_control_assertions #(.PC_INIT(PC_INIT)) u_assertions (
    .clock  (clock),
    .rst_n  (rst_n),
    .ior    (ior),
    .jump   (jump),
    .cancel (cancel),
    .pc     (pc)
);

/* bench/flow_control_tb.sv */
// Runs the DUT with default parameters (4 branches, config base 16, PC_INIT 0) against a model
`timescale 1ns/1ps

module flow_control_tb
    import flow_pkg::*;
;
    localparam int NB   = 4;
    localparam int BASE = 16;

    logic  clock = 1'b0;
    logic  rst_n = 1'b1;
    logic  ior = 1'b0, ior_previous = 1'b0, cancel_previous = 1'b0;
    logic  a_negative = 1'b0, a_carryout = 1'b0, a_external = 1'b0;
    logic  b_lessthan = 1'b0, b_external = 1'b0;
    addr_t config_addr = '0;
    word_t config_data = '0;
    logic  cancel;
    pc_t   pc;

    // Software copy of the pipeline
    pc_t   m_pc, m_dest;
    pc_t   m_q [2];
    logic  m_jump, m_cancel;
    pc_t   m_origin [NB];
    pc_t   m_destn [NB];
    logic  m_annul [NB];
    cond_t m_cond [NB];

    int    errors = 0, pass_count = 0, fail_count = 0, test_start = 0;
    string test_name = "reset";

    flow_control DUT (.*);

    always #20 clock = ~clock;

    function automatic logic cond_true(cond_t c);
        case (c)
            cond_always:       return 1'b1;
            cond_negative:     return a_negative;
            cond_not_negative: return !a_negative;
            cond_carryout:     return a_carryout;
            cond_a_external:   return a_external;
            cond_lessthan:     return b_lessthan;
            cond_not_lessthan: return !b_lessthan;
            default:           return b_external;
        endcase
    endfunction

    function automatic void reset_model();
        m_pc = '0;
        m_q[0] = '0;
        m_q[1] = '0;
        m_jump = 1'b0;
        m_cancel = 1'b0;
        m_dest = '0;
        for (int i = 0; i < NB; i++) begin
            m_origin[i] = 10'h3FF;
            m_destn[i] = '0;
            m_annul[i] = 1'b0;
            m_cond[i] = cond_always;
        end
    endfunction

    // Advances the reference by one clock edge with the inputs seen at that edge
    function automatic void step_model();
        logic         fj;
        logic         fc;
        pc_t          fd;
        int           idx;
        config_word_u w;
        fj = 1'b0;
        fc = 1'b0;
        fd = '0;
        for (int i = NB - 1; i >= 0; i--) begin
            if (ior && m_q[1] == m_origin[i] && cond_true(m_cond[i])) begin
                fj = 1'b1;
                fc = m_annul[i];
                fd = m_destn[i];
            end
        end
        idx = int'(config_addr) - BASE;
        if (ior_previous && !cancel_previous && idx >= 0 && idx < NB * 3) begin
            w = config_data;
            case (idx % 3)
                0: m_origin[idx / 3] = w.as_pc.pc;
                1: m_destn[idx / 3] = w.as_pc.pc;
                default: begin
                    m_annul[idx / 3] = w.as_cond.annul;
                    m_cond[idx / 3] = w.as_cond.cond;
                end
            endcase
        end
        if (ior) begin
            m_q[1] = m_q[0];
            m_q[0] = m_pc;
            m_pc = m_jump ? m_dest : m_pc + pc_t'(1);
            m_jump = fj;
            m_cancel = fc;
            m_dest = fd;
        end
    endfunction

    task automatic check_pc(input pc_t exp, input pc_t act);
        if (exp !== act) begin
            errors++;
            $display("ERROR %s pc expected %h actual %h", test_name, exp, act);
        end
    endtask

    task automatic check_cancel(input logic exp, input logic act);
        if (exp !== act) begin
            errors++;
            $display("ERROR %s cancel expected %b actual %b", test_name, exp, act);
        end
    endtask

    // Model steps on the edge and outputs are checked mid-cycle
    initial begin
        reset_model();
        forever begin
            @(posedge clock);
            if (rst_n) step_model();
            @(negedge clock);
            if (!rst_n) reset_model();
            check_pc(m_pc, pc);
            check_cancel(m_cancel, cancel);
        end
    end

    task automatic apply_reset();
        @(posedge clock);
        rst_n <= 1'b0;
        repeat (2) @(posedge clock);
        rst_n <= 1'b1;
    endtask

    task automatic write_cfg(input int addr, input word_t data, input logic prev_ok,
                             input logic prev_cancel);
        @(posedge clock);
        config_addr <= addr_t'(addr);
        config_data <= data;
        ior_previous <= prev_ok;
        cancel_previous <= prev_cancel;
        @(posedge clock);
        config_addr <= '0;
        ior_previous <= 1'b0;
        cancel_previous <= 1'b0;
    endtask

    task automatic program_branch(input int b, input pc_t org, input pc_t dst, input cond_t c,
                                  input logic annul);
        config_word_u w;
        w = '0;
        w.as_pc.pc = org;
        write_cfg(BASE + b * 3, w, 1'b1, 1'b0);
        w.as_pc.pc = dst;
        write_cfg(BASE + b * 3 + 1, w, 1'b1, 1'b0);
        w = '0;
        w.as_cond.cond = c;
        w.as_cond.annul = annul;
        write_cfg(BASE + b * 3 + 2, w, 1'b1, 1'b0);
    endtask

    task automatic wait_pc(input pc_t target, input int limit);
        int n;
        n = 0;
        while (pc !== target && n < limit) begin
            @(negedge clock);
            n++;
        end
        if (pc !== target) begin
            errors++;
            $display("%s: pc never reached %h within %0d cycles", test_name, target, limit);
        end
    endtask

    // Holds ior low on about one cycle in four until pc shows the target
    task automatic stall_until_pc(input pc_t target, input int limit);
        int n;
        n = 0;
        while (pc !== target && n < limit) begin
            @(posedge clock);
            ior <= ($urandom % 4) != 0;
            @(negedge clock);
            n++;
        end
        if (pc !== target) begin
            errors++;
            $display("%s: pc never reached %h within %0d cycles", test_name, target, limit);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_start = errors;
        apply_reset();
    endtask

    task automatic end_test();
        if (errors == test_start) begin
            pass_count++;
            $display("PASS %s", test_name);
        end else begin
            fail_count++;
            $display("FAIL %s (%0d mismatches)", test_name, errors - test_start);
        end
    endtask

    initial begin
        void'($urandom(32'h230e));
        begin_test("sequential");
        ior <= 1'b1;
        repeat (1100) @(posedge clock);
        end_test();

        begin_test("unconditional_annul");
        program_branch(0, 10'd40, 10'd200, cond_always, 1'b1);
        wait_pc(10'd200, 100);
        end_test();

        begin_test("conditional_flags");
        for (int r = 0; r < 6; r++) begin
            apply_reset();
            for (int b = 0; b < NB; b++) begin
                program_branch(b, pc_t'(30 + b * 8), pc_t'(36 + b * 8),
                               cond_t'((r % 2) * 4 + b), logic'($urandom % 2));
            end
            repeat (40) begin
                @(posedge clock);
                {a_negative, a_carryout, a_external, b_lessthan, b_external} <= 5'($urandom);
            end
        end
        end_test();

        begin_test("priority");
        program_branch(2, 10'd50, 10'd300, cond_always, 1'b0);
        program_branch(1, 10'd50, 10'd120, cond_always, 1'b1);
        wait_pc(10'd120, 100);
        end_test();

        begin_test("write_gating");
        program_branch(0, 10'd60, 10'd200, cond_always, 1'b0);
        write_cfg(BASE + 1, 16'd300, 1'b0, 1'b0);
        write_cfg(BASE + 1, 16'd310, 1'b1, 1'b1);
        wait_pc(10'd200, 100);
        end_test();

        begin_test("ior_stall");
        program_branch(0, 10'd70, 10'd100, cond_always, 1'b0);
        @(posedge clock);
        ior <= 1'b0;
        write_cfg(BASE + 1, 16'd150, 1'b1, 1'b0);
        stall_until_pc(10'd150, 400);
        end_test();

        $display("summary pass_count=%0d fail_count=%0d", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the flow_control testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module flow_control_tb -o sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -qx "test passed" sim.log; then
    exit 0
fi
exit 1

/* src.f */
verilog/flow_pkg.sv
verilog/flow_flags_if.sv
verilog/branch_unit.sv
verilog/branch_bank.sv
verilog/branch_arbiter.sv
verilog/pc_controller.sv
verilog/delay_line.sv
verilog/flow_control.sv
bench/flow_control_assertions.sv
bench/flow_control_tb.sv

/* verilog/branch_arbiter.sv */
// Lowest index wins; outputs are registered so they lag the firing step by one ior step
`timescale 1ns/1ps

module branch_arbiter
    import flow_pkg::*;
#(
    parameter int BRANCH_COUNT = 4
)
(
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    ior,
    input  logic [BRANCH_COUNT-1:0] jumps,
    input  logic [BRANCH_COUNT-1:0] cancels,
    input  pc_t                     destinations [BRANCH_COUNT],
    output logic                    jump,
    output logic                    cancel,
    output pc_t                     jump_destination
);

    logic sel_jump;
    logic sel_cancel;
    pc_t  sel_dest;

    // Scan from the top down so bit 0 is applied last and wins
    always_comb begin
        sel_jump   = 1'b0;
        sel_cancel = 1'b0;
        sel_dest   = '0;
        for (int i = BRANCH_COUNT - 1; i >= 0; i--) begin
            if (jumps[i]) begin
                sel_jump   = 1'b1;
                sel_cancel = cancels[i];
                sel_dest   = destinations[i];
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            jump             <= 1'b0;
            cancel           <= 1'b0;
            jump_destination <= '0;
        end else if (ior) begin
            jump             <= sel_jump;
            cancel           <= sel_cancel;
            jump_destination <= sel_dest;
        end
    end

endmodule

/* verilog/branch_bank.sv */
// Branch configs sit back to back from CONFIG_ADDR_BASE; the last address must fit in 8 bits
`timescale 1ns/1ps

module branch_bank
    import flow_pkg::*;
#(
    parameter int BRANCH_COUNT     = 4,
    parameter int CONFIG_ADDR_BASE = 16
)
(
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    ior,
    input  logic                    ior_previous,
    input  logic                    cancel_previous,
    input  pc_t                     pc_current,
    flow_flags_if.sink              flags,
    input  addr_t                   config_addr,
    input  word_t                   config_data,
    output logic [BRANCH_COUNT-1:0] jumps,
    output logic [BRANCH_COUNT-1:0] cancels,
    output pc_t                     destinations [BRANCH_COUNT]
);

    logic config_wren;

    // Writing instruction must have completed and not been annulled
    assign config_wren = ior_previous && !cancel_previous;

    // ------------------------------------------------------------
    // One unit per parallel branch, consecutive config blocks
    // ------------------------------------------------------------

    for (genvar i = 0; i < BRANCH_COUNT; i++) begin : g_branch
        branch_unit #(
            .CONFIG_BASE (CONFIG_ADDR_BASE + i * BRANCH_CONFIG_ENTRIES)
        ) u_branch (
            .clock       (clock),
            .rst_n       (rst_n),
            .ior         (ior),
            .config_wren (config_wren),
            .config_addr (config_addr),
            .config_data (config_data),
            .pc_current  (pc_current),
            .flags       (flags),
            .jump        (jumps[i]),
            .cancel      (cancels[i]),
            .destination (destinations[i])
        );
    end

endmodule

/* verilog/branch_unit.sv */
// Config lives in flops at CONFIG_BASE..+2; unprogrammed origin 10'h3FF can still match
`timescale 1ns/1ps

module branch_unit
    import flow_pkg::*;
#(
    parameter int CONFIG_BASE = 0
)
(
    input  logic              clock,
    input  logic              rst_n,
    input  logic              ior,
    input  logic              config_wren,
    input  addr_t             config_addr,
    input  word_t             config_data,
    input  pc_t               pc_current,
    flow_flags_if.sink        flags,
    output logic              jump,
    output logic              cancel,
    output pc_t               destination
);

    localparam addr_t ORIGIN_ADDR = addr_t'(CONFIG_BASE);
    localparam addr_t DEST_ADDR   = addr_t'(CONFIG_BASE + 1);
    localparam addr_t COND_ADDR   = addr_t'(CONFIG_BASE + 2);

    config_word_u wr_word;
    pc_t          origin;
    logic         annul;
    cond_t        cond_sel;
    logic         flag_ok;

    assign wr_word = config_data;

    // ------------------------------------------------------------
    // Configuration registers
    // ------------------------------------------------------------

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            origin      <= 10'h3FF;
            destination <= '0;
            annul       <= 1'b0;
            cond_sel    <= cond_always;
        end else if (config_wren) begin
            if (config_addr == ORIGIN_ADDR) begin
                origin <= wr_word.as_pc.pc;
            end
            if (config_addr == DEST_ADDR) begin
                destination <= wr_word.as_pc.pc;
            end
            if (config_addr == COND_ADDR) begin
                annul    <= wr_word.as_cond.annul;
                cond_sel <= wr_word.as_cond.cond;
            end
        end
    end

    // ------------------------------------------------------------
    // Flag test and origin match
    // ------------------------------------------------------------

    always_comb begin
        case (cond_sel)
            cond_always:       flag_ok = 1'b1;
            cond_negative:     flag_ok = flags.a_negative;
            cond_not_negative: flag_ok = !flags.a_negative;
            cond_carryout:     flag_ok = flags.a_carryout;
            cond_a_external:   flag_ok = flags.a_external;
            cond_lessthan:     flag_ok = flags.b_lessthan;
            cond_not_lessthan: flag_ok = !flags.b_lessthan;
            cond_b_external:   flag_ok = flags.b_external;
            default:           flag_ok = 1'b0;
        endcase
    end

    // Only an instruction that is actually leaving fetch can trigger
    assign jump   = ior && (pc_current == origin) && flag_ok;
    assign cancel = jump && annul;

endmodule

/* verilog/delay_line.sv */
// DEPTH must be at least 1; the chain shifts only on ior steps
`timescale 1ns/1ps

module delay_line
    import flow_pkg::*;
#(
    parameter int  DEPTH       = 2,
    parameter pc_t RESET_VALUE = '0
)
(
    input  logic clock,
    input  logic rst_n,
    input  logic ior,
    input  pc_t  in,
    output pc_t  out
);

    pc_t stages [DEPTH];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= RESET_VALUE;
            end
        end else if (ior) begin
            stages[0] <= in;
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i - 1];
            end
        end
    end

    assign out = stages[DEPTH - 1];

endmodule

/* verilog/flow_control.sv */
// Single thread, flop-based config, no write retiming; flags must match the PC at pc_current
`timescale 1ns/1ps

module flow_control
    import flow_pkg::*;
#(
    parameter int  BRANCH_COUNT     = 4,
    parameter int  CONFIG_ADDR_BASE = 16,
    parameter pc_t PC_INIT          = '0
)
(
    input  logic  clock,
    input  logic  rst_n,
    input  logic  ior,
    input  logic  ior_previous,
    input  logic  cancel_previous,
    input  logic  a_negative,
    input  logic  a_carryout,
    input  logic  a_external,
    input  logic  b_lessthan,
    input  logic  b_external,
    input  addr_t config_addr,
    input  word_t config_data,
    output logic  cancel,
    output pc_t   pc
);

    pc_t                     pc_current;
    logic [BRANCH_COUNT-1:0] jumps;
    logic [BRANCH_COUNT-1:0] cancels;
    pc_t                     destinations [BRANCH_COUNT];
    logic                    jump;
    pc_t                     jump_destination;

    // ------------------------------------------------------------
    // Condition flags into the shared bundle
    // ------------------------------------------------------------

    flow_flags_if flags ();

    assign flags.a_negative = a_negative;
    assign flags.a_carryout = a_carryout;
    assign flags.a_external = a_external;
    assign flags.b_lessthan = b_lessthan;
    assign flags.b_external = b_external;

    // Realign the issued PC with the instruction now leaving fetch
    delay_line #(
        .DEPTH       (FETCH_PIPE_DEPTH),
        .RESET_VALUE (PC_INIT)
    ) u_delay (
        .clock (clock),
        .rst_n (rst_n),
        .ior   (ior),
        .in    (pc),
        .out   (pc_current)
    );

    // ------------------------------------------------------------
    // Branch evaluation, arbitration and PC issue
    // ------------------------------------------------------------

    branch_bank #(
        .BRANCH_COUNT     (BRANCH_COUNT),
        .CONFIG_ADDR_BASE (CONFIG_ADDR_BASE)
    ) u_bank (
        .clock           (clock),
        .rst_n           (rst_n),
        .ior             (ior),
        .ior_previous    (ior_previous),
        .cancel_previous (cancel_previous),
        .pc_current      (pc_current),
        .flags           (flags.sink),
        .config_addr     (config_addr),
        .config_data     (config_data),
        .jumps           (jumps),
        .cancels         (cancels),
        .destinations    (destinations)
    );

    branch_arbiter #(
        .BRANCH_COUNT (BRANCH_COUNT)
    ) u_arbiter (
        .clock            (clock),
        .rst_n            (rst_n),
        .ior              (ior),
        .jumps            (jumps),
        .cancels          (cancels),
        .destinations     (destinations),
        .jump             (jump),
        .cancel           (cancel),
        .jump_destination (jump_destination)
    );

    pc_controller #(
        .PC_INIT (PC_INIT)
    ) u_pc (
        .clock            (clock),
        .rst_n            (rst_n),
        .ior              (ior),
        .jump             (jump),
        .jump_destination (jump_destination),
        .pc               (pc)
    );

endmodule

/* verilog/flow_flags_if.sv */
// Flags must belong to the instruction at pc_current in the same cycle
`timescale 1ns/1ps

interface flow_flags_if;

    // ALU A side results and external condition
    logic a_negative;
    logic a_carryout;
    logic a_external;

    // ALU B side results and external condition
    logic b_lessthan;
    logic b_external;

    modport source (
        output a_negative, a_carryout, a_external,
        output b_lessthan, b_external
    );

    modport sink (
        input a_negative, a_carryout, a_external,
        input b_lessthan, b_external
    );

endinterface

/* verilog/flow_pkg.sv */
// Sized for a 10-bit PC core with 8-bit config addresses and 16-bit config words only
package flow_pkg;

    // ------------------------------------------------------------
    // Basic datapath types
    // ------------------------------------------------------------

    typedef logic [9:0]  pc_t;
    typedef logic [15:0] word_t;
    typedef logic [7:0]  addr_t;

    // Flag tests selectable by a branch condition word
    typedef enum logic [2:0] {
        cond_always       = 3'd0,
        cond_negative     = 3'd1,
        cond_not_negative = 3'd2,
        cond_carryout     = 3'd3,
        cond_a_external   = 3'd4,
        cond_lessthan     = 3'd5,
        cond_not_lessthan = 3'd6,
        cond_b_external   = 3'd7
    } cond_t;

    // ------------------------------------------------------------
    // Configuration word layouts
    // ------------------------------------------------------------

    // Condition entry with the annul bit and flag test in the low nibble
    typedef struct packed {
        logic [11:0] spare;
        logic        annul;
        cond_t       cond;
    } cond_word_t;

    // Origin and destination entries carry a PC in the low bits
    typedef struct packed {
        logic [5:0] spare;
        pc_t        pc;
    } pc_word_t;

    // One written word, decoded either as a PC or as a condition
    typedef union packed {
        pc_word_t   as_pc;
        cond_word_t as_cond;
    } config_word_u;

    // ------------------------------------------------------------
    // Fixed constants
    // ------------------------------------------------------------

    // Origin at offset 0, destination at 1, condition at 2
    localparam int BRANCH_CONFIG_ENTRIES = 3;

    // Ready steps from issuing a PC to its instruction being tested
    localparam int FETCH_PIPE_DEPTH = 2;

endpackage

/* verilog/pc_controller.sv */
// Single thread only; the PC wraps at 10 bits and restarts at PC_INIT on reset
`timescale 1ns/1ps

module pc_controller
    import flow_pkg::*;
#(
    parameter pc_t PC_INIT = '0
)
(
    input  logic clock,
    input  logic rst_n,
    input  logic ior,
    input  logic jump,
    input  pc_t  jump_destination,
    output pc_t  pc
);

    pc_t pc_next;

    // Taken branch overrides the sequential address
    always_comb begin
        if (jump) begin
            pc_next = jump_destination;
        end else begin
            pc_next = pc + pc_t'(1);
        end
    end

    // Issue a new PC only on ready steps
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc <= PC_INIT;
        end else if (ior) begin
            pc <= pc_next;
        end
    end

endmodule
